//--- bench/dsp_cluster_tb.sv
/* Testbench for the DSP cluster: LCG stimulus, lane reference model
   and concurrent checks on grants and results */

`default_nettype none

module dsp_cluster_tb;

    localparam int clients_n = 2;

    logic                   clk;
    logic                   arst_n;
    dsp_pkg::dsp_operands_t client_operands [clients_n];
    logic [clients_n-1:0]   client_req;
    dsp_pkg::dsp_result_t   client_result [clients_n];
    logic [clients_n-1:0]   client_gnt;

    dsp_pkg::dsp_result_t   exp_result [clients_n];
    logic [31:0]            lcg_state;
    int                     assert_errs;
    int                     timeouts;
    int                     tests_passed;
    int                     tests_failed;
    bit                     idle_check;
    bit                     solo;
    bit                     alt_mode;
    bit                     have_last;
    int                     last_idx;

    dsp_cluster #(
        .clients_n (clients_n)
    ) uut (
        .clk             (clk),
        .arst_n          (arst_n),
        .client_operands (client_operands),
        .client_req      (client_req),
        .client_result   (client_result),
        .client_gnt      (client_gnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Signed product taken to 64 bits, then cut to the 48-bit accumulator
    function automatic logic [47:0] lane_model(input logic [7:0] op,
                                               input dsp_pkg::dsp_lane_in_t l);
        longint prod;
        logic [47:0] p48;
        prod = longint'($signed(l.a)) * longint'($signed(l.b));
        p48 = prod[47:0];
        case (op)
            dsp_pkg::op_mul:    return p48;
            dsp_pkg::op_madd:   return l.c + p48;
            dsp_pkg::op_msub:   return l.c - p48;
            dsp_pkg::op_pass_c: return l.c;
            default:            return 48'h0;
        endcase
    endfunction

    function automatic dsp_pkg::dsp_lane_in_t random_lane(input bit extreme);
        dsp_pkg::dsp_lane_in_t l;
        logic [17:0] edge_ab [4];
        logic [47:0] edge_c [4];
        edge_ab = '{18'h20000, 18'h1ffff, 18'h3ffff, 18'h00000};
        edge_c  = '{48'hffff_ffff_ffff, 48'h8000_0000_0000, 48'h7fff_ffff_ffff, 48'h0};
        if (extreme) begin
            l.a = edge_ab[lcg_next() % 4];
            l.b = edge_ab[lcg_next() % 4];
            l.c = edge_c[lcg_next() % 4];
        end else begin
            l.a = lcg_next();
            l.b = lcg_next();
            l.c = {lcg_next(), lcg_next()};
        end
        return l;
    endfunction

    function automatic dsp_pkg::dsp_operands_t make_ops(input logic [7:0] code,
                                                        input bit extreme);
        dsp_pkg::dsp_operands_t o;
        o.op    = dsp_pkg::dsp_opcode_e'(code);
        o.left  = random_lane(extreme);
        o.right = random_lane(extreme);
        return o;
    endfunction

    task automatic drive_ops(input int idx, input dsp_pkg::dsp_operands_t o);
        client_operands[idx] = o;
        exp_result[idx].pl   = lane_model(o.op, o.left);
        exp_result[idx].pr   = lane_model(o.op, o.right);
    endtask

    // One transaction from a single client, req dropped after the grant
    task automatic run_solo(input int idx, input dsp_pkg::dsp_operands_t o);
        bit seen;
        seen = 1'b0;
        @(negedge clk);
        drive_ops(idx, o);
        client_req[idx] = 1'b1;
        for (int t = 0; t < 20 && !seen; t++) begin
            @(negedge clk);
            seen = client_gnt[idx];
        end
        if (!seen) begin
            $display("Timeout: client %0d got no grant within 20 cycles", idx);
            timeouts++;
        end
        @(negedge clk);
        client_req[idx] = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = assert_errs + timeouts - errs_before;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!alt_mode) begin
            have_last <= 1'b0;
        end else if (|client_gnt) begin
            have_last <= 1'b1;
            last_idx  <= client_gnt[1] ? 1 : 0;
        end
    end

    a_idle_gnt: assert property (@(posedge clk) disable iff (!arst_n)
        idle_check |-> client_gnt == '0)
        else begin
            assert_errs++;
            $display("FAILED client_gnt expected %h actual %h", 2'h0, $sampled(client_gnt));
        end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        |client_gnt |-> $onehot(client_gnt))
        else begin
            assert_errs++;
            $display("FAILED client_gnt is not one-hot, actual %h", $sampled(client_gnt));
        end

    for (genvar g = 0; g < clients_n; g++) begin : g_chk
        a_latency: assert property (@(posedge clk) disable iff (!arst_n)
            (solo && $rose(client_req[g])) |-> ##3 client_gnt[g])
            else begin
                assert_errs++;
                $display("FAILED client_gnt[%0d] expected %h actual %h", g, 1'b1, 1'b0);
            end

        a_result: assert property (@(posedge clk) disable iff (!arst_n)
            client_gnt[g] |-> client_result[g] == exp_result[g])
            else begin
                assert_errs++;
                $display("FAILED client_result[%0d] expected %h actual %h", g,
                         $sampled(exp_result[g]), $sampled(client_result[g]));
            end

        a_alternate: assert property (@(posedge clk) disable iff (!arst_n)
            (alt_mode && have_last && client_gnt[g]) |-> last_idx != g)
            else begin
                assert_errs++;
                $display("Grants did not alternate, client %0d was served twice", g);
            end

        for (genvar h = 0; h < clients_n; h++) begin : g_other
            if (h != g) begin : g_zero
                a_other_zero: assert property (@(posedge clk) disable iff (!arst_n)
                    client_gnt[g] |-> client_result[h] == '0)
                    else begin
                        assert_errs++;
                        $display("FAILED client_result[%0d] expected %h actual %h", h,
                                 96'h0, $sampled(client_result[h]));
                    end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0] codes [5];
        dsp_pkg::dsp_operands_t o;
        int errs_before;
        int served;
        bit refresh [clients_n];
        codes = '{dsp_pkg::op_mul, dsp_pkg::op_madd, dsp_pkg::op_msub,
                  dsp_pkg::op_pass_c, 8'h5a};
        lcg_state = 32'h6af5cd70;
        arst_n = 1'b0;
        client_req = '0;
        for (int i = 0; i < clients_n; i++) begin
            client_operands[i] = '0;
            exp_result[i] = '0;
            refresh[i] = 1'b0;
        end
        assert_errs = 0;
        timeouts = 0;
        tests_passed = 0;
        tests_failed = 0;
        idle_check = 1'b0;
        solo = 1'b0;
        alt_mode = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;

        // Nothing requested, so no grant may appear
        errs_before = 0;
        idle_check = 1'b1;
        repeat (10) @(negedge clk);
        idle_check = 1'b0;
        report_test("reset_idle", errs_before);

        errs_before = assert_errs + timeouts;
        solo = 1'b1;
        for (int k = 0; k < 5; k++) begin
            run_solo(0, make_ops(codes[k], 1'b0));
        end
        report_test("opcodes_solo", errs_before);

        // Largest product plus all-ones c must wrap past 2^48
        errs_before = assert_errs + timeouts;
        o.op = dsp_pkg::op_madd;
        o.left = '{a: 18'h20000, b: 18'h20000, c: 48'hffff_ffff_ffff};
        o.right = '{a: 18'h1ffff, b: 18'h20000, c: 48'h0};
        run_solo(1, o);
        for (int k = 0; k < 12; k++) begin
            run_solo(1, make_ops(codes[k % 4], 1'b1));
        end
        solo = 1'b0;
        report_test("extremes_wrap", errs_before);

        errs_before = assert_errs + timeouts;
        served = 0;
        @(negedge clk);
        alt_mode = 1'b1;
        for (int i = 0; i < clients_n; i++) begin
            drive_ops(i, make_ops(codes[lcg_next() % 4], 1'b0));
        end
        client_req = '1;
        for (int t = 0; t < 200 && served < 10; t++) begin
            @(negedge clk);
            for (int i = 0; i < clients_n; i++) begin
                if (refresh[i]) begin
                    drive_ops(i, make_ops(codes[lcg_next() % 4], 1'b0));
                    refresh[i] = 1'b0;
                end
                if (client_gnt[i]) begin
                    refresh[i] = 1'b1;
                    served++;
                end
            end
        end
        if (served < 10) begin
            $display("Timeout: only %0d of 10 grants seen with both clients busy", served);
            timeouts++;
        end
        @(negedge clk);
        client_req = '0;
        alt_mode = 1'b0;
        repeat (6) @(negedge clk);
        report_test("round_robin", errs_before);

        $display("tests passed %0d, tests failed %0d, check errors %0d, timeouts %0d",
                 tests_passed, tests_failed, assert_errs, timeouts);
        if (tests_failed == 0 && assert_errs == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/arb_rr.sv
/* Round-robin arbiter with a grant locked from issue until done */

`default_nettype none

module arb_rr #(
    parameter int clients_n = 2
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic [clients_n-1:0] req,
    input  wire logic                 done,
    output logic      [clients_n-1:0] gnt
);

    localparam int idx_w = (clients_n > 1) ? $clog2(clients_n) : 1;

    logic             locked_q;
    logic [idx_w-1:0] cur_q;
    logic [idx_w-1:0] ptr_q;
    logic [idx_w-1:0] pick_idx;
    logic             pick_any;

    // First requester after the last one served
    always_comb begin
        int idx;
        pick_idx = ptr_q;
        pick_any = 1'b0;
        for (int k = 1; k <= clients_n; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= clients_n) begin
                idx = idx - clients_n;
            end
            if (!pick_any && req[idx]) begin
                pick_any = 1'b1;
                pick_idx = idx_w'(idx);
            end
        end
    end

    // Unlocked grant follows the pick so an idle engine can accept at once
    assign gnt = locked_q ? (clients_n'(1) << cur_q)
               : (pick_any ? (clients_n'(1) << pick_idx) : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked_q <= 1'b0;
            cur_q    <= '0;
            ptr_q    <= idx_w'(clients_n - 1);
        end else if (!locked_q) begin
            if (pick_any) begin
                locked_q <= 1'b1;
                cur_q    <= pick_idx;
            end
        end else if (done) begin
            locked_q <= 1'b0;
            ptr_q    <= cur_q;
        end
    end

    // Done may only close a transaction that holds exactly one grant
    a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> (locked_q && $onehot(gnt)));

    // A grant once given stays put until the engine reports done
    a_gnt_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (|gnt && !done) |=> (gnt == $past(gnt)));

endmodule

`default_nettype wire

//--- design/dsp_cluster.sv
/* DSP cluster top: client interconnect feeding the shared MAC engine */

`default_nettype none

module dsp_cluster #(
    parameter int clients_n = 2
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire dsp_pkg::dsp_operands_t client_operands [clients_n],
    input  wire logic [clients_n-1:0]   client_req,
    output dsp_pkg::dsp_result_t        client_result [clients_n],
    output logic [clients_n-1:0]        client_gnt
);

    //////////////////////////////////////////////////////////////////////
    // Interconnect to engine wiring
    //////////////////////////////////////////////////////////////////////

    dsp_pkg::dsp_operands_t dsp_operands;
    logic                   dsp_req;
    dsp_pkg::dsp_result_t   dsp_result;
    logic                   dsp_done;

    dsp_nic #(
        .clients_n (clients_n)
    ) u_nic (
        .clk             (clk),
        .arst_n          (arst_n),
        .client_operands (client_operands),
        .client_req      (client_req),
        .client_result   (client_result),
        .client_gnt      (client_gnt),
        .dsp_operands    (dsp_operands),
        .dsp_req         (dsp_req),
        .dsp_result      (dsp_result),
        .dsp_done        (dsp_done)
    );

    dsp_engine u_engine (
        .clk          (clk),
        .arst_n       (arst_n),
        .dsp_req      (dsp_req),
        .dsp_operands (dsp_operands),
        .dsp_result   (dsp_result),
        .dsp_done     (dsp_done)
    );

endmodule

`default_nettype wire

//--- design/dsp_engine.sv
/* Dual-lane MAC engine with idle/busy control and result join */

`default_nettype none

module dsp_engine (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   dsp_req,
    input  wire dsp_pkg::dsp_operands_t dsp_operands,
    output dsp_pkg::dsp_result_t        dsp_result,
    output logic                        dsp_done
);

    typedef enum logic {
        st_idle,
        st_busy
    } engine_state_e;

    engine_state_e           state_q;
    logic                    start;
    logic [dsp_pkg::p_w-1:0] left_p;
    logic                    left_valid;
    logic [dsp_pkg::p_w-1:0] right_p;
    logic                    right_valid;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    // Lanes capture on the same edge the request is accepted
    assign start = dsp_req && (state_q == st_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else if (start) begin
            state_q <= st_busy;
        end else if (dsp_done) begin
            state_q <= st_idle;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    dsp_mac_lane u_lane_left (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .op       (dsp_operands.op),
        .operands (dsp_operands.left),
        .p        (left_p),
        .valid    (left_valid)
    );

    dsp_mac_lane u_lane_right (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .op       (dsp_operands.op),
        .operands (dsp_operands.right),
        .p        (right_p),
        .valid    (right_valid)
    );

    dsp_result_join u_join (
        .clk         (clk),
        .arst_n      (arst_n),
        .left_p      (left_p),
        .left_valid  (left_valid),
        .right_p     (right_p),
        .right_valid (right_valid),
        .result      (dsp_result),
        .done        (dsp_done)
    );

    // A launch only finds drained lanes and no pending result
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !(left_valid || right_valid || dsp_done));

    // Done arrives exactly three cycles after a launch
    a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> ##3 dsp_done);

endmodule

`default_nettype wire

//--- design/dsp_mac_lane.sv
/* Signed 18x18 multiply-accumulate lane, two register stages */

`default_nettype none

module dsp_mac_lane (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  start,
    input  wire dsp_pkg::dsp_opcode_e  op,
    input  wire dsp_pkg::dsp_lane_in_t operands,
    output logic [dsp_pkg::p_w-1:0]    p,
    output logic                       valid
);

    localparam int prod_w = 2 * dsp_pkg::a_w;

    logic                      s1_valid;
    logic signed [prod_w-1:0]  prod_q;
    logic [dsp_pkg::p_w-1:0]   c_q;
    dsp_pkg::dsp_opcode_e      op_q;
    logic [dsp_pkg::p_w-1:0]   prod_ext;
    logic [dsp_pkg::p_w-1:0]   p_next;

    //////////////////////////////////////////////////////////////////////
    // Stage 1 multiply
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            prod_q <= $signed(operands.a) * $signed(operands.b);
            c_q    <= operands.c;
            op_q   <= op;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2 accumulate
    //////////////////////////////////////////////////////////////////////

    assign prod_ext = {{(dsp_pkg::p_w - prod_w){prod_q[prod_w-1]}}, prod_q};

    // Sums wrap at the accumulator width
    always_comb begin
        case (op_q)
            dsp_pkg::op_mul:    p_next = prod_ext;
            dsp_pkg::op_madd:   p_next = c_q + prod_ext;
            dsp_pkg::op_msub:   p_next = c_q - prod_ext;
            dsp_pkg::op_pass_c: p_next = c_q;
            default:            p_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            p <= p_next;
        end
    end

endmodule

`default_nettype wire

//--- design/dsp_nic.sv
/* Client interconnect: arbitration, operand mux toward the engine
   and result and grant routing back to the granted client */

`default_nettype none

module dsp_nic #(
    parameter int clients_n = 2
) (
    input  wire logic                   clk,
    input  wire logic                   arst_n,

    // Client side
    input  wire dsp_pkg::dsp_operands_t client_operands [clients_n],
    input  wire logic [clients_n-1:0]   client_req,
    output dsp_pkg::dsp_result_t        client_result [clients_n],
    output logic [clients_n-1:0]        client_gnt,

    // Engine side
    output dsp_pkg::dsp_operands_t      dsp_operands,
    output logic                        dsp_req,
    input  wire dsp_pkg::dsp_result_t   dsp_result,
    input  wire logic                   dsp_done
);

    logic [clients_n-1:0] arb_gnt;

    //////////////////////////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////////////////////////

    arb_rr #(
        .clients_n (clients_n)
    ) u_arb (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (client_req),
        .done   (dsp_done),
        .gnt    (arb_gnt)
    );

    // Engine only sees the request of the client that holds the grant
    assign dsp_req = |(client_req & arb_gnt);

    // Grant pulse to the client comes with the engine's done
    assign client_gnt = arb_gnt & {clients_n{dsp_done}};

    //////////////////////////////////////////////////////////////////////
    // Data routing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dsp_operands = '0;
        for (int i = 0; i < clients_n; i++) begin
            if (arb_gnt[i]) begin
                dsp_operands = client_operands[i];
            end
        end
    end

    // Results only reach the granted client, others read zero
    always_comb begin
        for (int i = 0; i < clients_n; i++) begin
            if (arb_gnt[i]) begin
                client_result[i] = dsp_result;
            end else begin
                client_result[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dsp_pkg.sv
/* Shared widths, opcode encoding and the operand and result bundles
   exchanged between clients, interconnect and MAC engine */

`default_nettype none

package dsp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Opcode field
    localparam int op_w = 8;
    // Multiplier operands a and b
    localparam int a_w = 18;
    // Accumulator input c and results
    localparam int p_w = 48;

    //////////////////////////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////////////////////////

    // Codes outside this set produce a zero result
    typedef enum logic [op_w-1:0] {
        op_mul    = 8'h01,
        op_madd   = 8'h02,
        op_msub   = 8'h03,
        op_pass_c = 8'h04
    } dsp_opcode_e;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    // Operands of a single lane
    typedef struct packed {
        logic [a_w-1:0] a;
        logic [a_w-1:0] b;
        logic [p_w-1:0] c;
    } dsp_lane_in_t;

    // Full request as issued by a client
    typedef struct packed {
        dsp_opcode_e  op;
        dsp_lane_in_t left;
        dsp_lane_in_t right;
    } dsp_operands_t;

    typedef struct packed {
        logic [p_w-1:0] pl;
        logic [p_w-1:0] pr;
    } dsp_result_t;

endpackage

`default_nettype wire

//--- design/dsp_result_join.sv
/* Merges left and right lane outputs into one result with done */

`default_nettype none

module dsp_result_join (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic [dsp_pkg::p_w-1:0] left_p,
    input  wire logic                    left_valid,
    input  wire logic [dsp_pkg::p_w-1:0] right_p,
    input  wire logic                    right_valid,
    output dsp_pkg::dsp_result_t         result,
    output logic                         done
);

    logic                 both_valid;
    dsp_pkg::dsp_result_t result_q;

    assign both_valid = left_valid & right_valid;

    // Done is a single-cycle pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= both_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (both_valid) begin
            result_q.pl <= left_p;
            result_q.pr <= right_p;
        end
    end

    assign result = result_q;

    // Both lanes are launched together and must finish together
    a_lanes_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        left_valid == right_valid);

endmodule

`default_nettype wire

//--- project.f
design/dsp_pkg.sv
design/arb_rr.sv
design/dsp_nic.sv
design/dsp_mac_lane.sv
design/dsp_result_join.sv
design/dsp_engine.sv
design/dsp_cluster.sv
bench/dsp_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DSP cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert --timing -Wno-fatal --top-module dsp_cluster_tb \
    -f project.f -o sim_dsp > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dsp > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation returned status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0
